// File: Makefile
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
TOP             ?= tb_mpf_top
FILE_LIST       ?= build.f
OBJ_DIR         ?= obj_dir

SOURCES  := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
PASS_MSG := Simulation finished: PASS

.PHONY: all run clean

all: run

# The simulator binary is rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
verilog/mpf_pkg.sv
verilog/write_data_heap.sv
verilog/req_fifo.sv
verilog/mpf_shim_pipe.sv
verilog/edge_connect.sv
verilog/mpf_top.sv
sim/edge_connect_asserts.sv
sim/tb_mpf_top.sv

// File: sim/edge_connect_asserts.sv
module edge_connect_asserts
#(
    parameter int N_HEAP_ENTRIES = 64
)
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              out_valid,
    input  logic                              heap_enq,
    input  logic                              heap_not_full,
    input  logic                              heap_free_en,
    input  logic [$clog2(N_HEAP_ENTRIES)-1:0] heap_free_idx,
    input  logic [$clog2(N_HEAP_ENTRIES)-1:0] heap_rd_ptr
);

    // ====================
    // Edge properties
    // ====================

    // The output header pipeline starts empty once reset has been seen
    assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid is high in the cycle after reset");

    // A well behaved sender never pushes a beat into a heap that reports near full
    assert property (@(posedge clk) disable iff (reset) heap_enq |-> heap_not_full)
        else $error("heap was enqueued while not_full was low");

    // Slots are released in allocation order, so the freed index is always the ring tail
    assert property (@(posedge clk) disable iff (reset)
                     heap_free_en |-> (heap_free_idx == heap_rd_ptr))
        else $error("heap freed an index other than the ring read pointer");

endmodule

// File: sim/tb_mpf_top.sv
module tb_mpf_top;

    import mpf_pkg::*;

    localparam int DATA_WIDTH = 512;
    localparam int N_HEAP_ENTRIES = 64;
    localparam int ALMOST_FULL_THRESHOLD = 4;
    localparam int PIPE_STAGES = 3;
    localparam int WAIT_TIMEOUT = 2000;

    // One expected FIU beat
    typedef struct packed {
        logic                  sop;
        cl_len_t               len;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } beat_t;

    logic                  clk;
    logic                  reset;
    logic                  wr_valid;
    logic                  wr_sop;
    cl_len_t               wr_len;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0] wr_data;
    logic                  wr_almost_full;
    logic                  out_valid;
    logic                  out_sop;
    cl_len_t               out_len;
    logic [ADDR_WIDTH-1:0] out_addr;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  out_almost_full;

    // Scoreboard of beats still owed by the DUT, oldest first
    beat_t expected_q[$];
    bit    stream_active;
    int    stalled_beats;

    mpf_top #(
        .DATA_WIDTH(DATA_WIDTH),
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES),
        .ALMOST_FULL_THRESHOLD(ALMOST_FULL_THRESHOLD),
        .PIPE_STAGES(PIPE_STAGES)
    ) DUT (
        .clk(clk), .reset(reset),
        .wr_valid(wr_valid), .wr_sop(wr_sop), .wr_len(wr_len), .wr_addr(wr_addr),
        .wr_data(wr_data), .wr_almost_full(wr_almost_full),
        .out_valid(out_valid), .out_sop(out_sop), .out_len(out_len), .out_addr(out_addr),
        .out_data(out_data), .out_almost_full(out_almost_full)
    );

    // The heap signals are taken at the edge level, the ring pointer from inside the heap
    bind edge_connect edge_connect_asserts #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES)
    ) asserts_i (
        .clk(clk), .reset(reset), .out_valid(out_valid),
        .heap_enq(wr_valid), .heap_not_full(heap_not_full),
        .heap_free_en(beat_go), .heap_free_idx(heap_read_idx),
        .heap_rd_ptr(wr_heap.rd_ptr)
    );

    always #10 clk = ~clk;

    // ====================
    // Helpers
    // ====================

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                               input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [DATA_WIDTH-1:0] random_line();
        logic [DATA_WIDTH-1:0] line;
        for (int i = 0; i < DATA_WIDTH / 32; i++)
        begin
            line[i*32 +: 32] = $urandom;
        end
        return line;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] random_addr();
        logic [63:0] wide;
        wide = {$urandom, $urandom};
        return wide[ADDR_WIDTH-1:0];
    endfunction

    function automatic cl_len_t random_len();
        cl_len_t len;
        case ($urandom_range(2, 0))
            0: len = CL_LEN_1;
            1: len = CL_LEN_2;
            default: len = CL_LEN_4;
        endcase
        return len;
    endfunction

    // Waits for wr_almost_full to be low, then drives one beat on the next edge
    // The expected beat is queued at the decision point, half a cycle before the drive
    task automatic send_beat(input logic sop, input cl_len_t len,
                             input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data);
        int    waited;
        beat_t beat;
        waited = 0;
        @(negedge clk);
        while (wr_almost_full)
        begin
            waited++;
            if (waited > WAIT_TIMEOUT)
            begin
                $display("timeout waiting for wr_almost_full to clear");
                stop_run();
            end
            @(posedge clk);
            wr_valid <= 1'b0;
            wr_sop <= 1'b0;
            @(negedge clk);
        end
        beat.sop = sop;
        beat.len = len;
        beat.addr = addr;
        beat.data = data;
        expected_q.push_back(beat);
        @(posedge clk);
        wr_valid <= 1'b1;
        wr_sop <= sop;
        wr_len <= len;
        wr_addr <= addr;
        wr_data <= data;
    endtask

    // Beat count is the length code plus one, and only beat zero carries sop
    task automatic send_request(input cl_len_t len, input logic [ADDR_WIDTH-1:0] addr);
        int n_beats;
        n_beats = int'(len) + 1;
        for (int k = 0; k < n_beats; k++)
        begin
            send_beat(k == 0, len, addr, random_line());
        end
    endtask

    task automatic end_stream();
        @(posedge clk);
        wr_valid <= 1'b0;
        wr_sop <= 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_TIMEOUT)
            begin
                $display("timeout waiting for %0d output beats to drain", expected_q.size());
                stop_run();
            end
        end
    endtask

    // Toggles sink back-pressure in random stretches until the driver is done
    task automatic throttle_sink();
        int stretch;
        int cycles;
        stretch = 0;
        cycles = 0;
        while (stream_active)
        begin
            @(posedge clk);
            if (stretch == 0)
            begin
                out_almost_full <= !out_almost_full;
                stretch = $urandom_range(8, 1);
            end
            else
            begin
                stretch--;
            end
            cycles++;
            if (cycles > WAIT_TIMEOUT * 4)
            begin
                $display("timeout while the stalled stream was still being sent");
                stop_run();
            end
        end
        @(posedge clk);
        out_almost_full <= 1'b0;
    endtask

    // ====================
    // Output monitor
    // ====================

    always @(negedge clk)
    begin : monitor
        beat_t exp_beat;
        if (!reset)
        begin
            // Only beats decided before the sink stalled may still come out
            if (!out_almost_full)
            begin
                stalled_beats = 0;
            end
            else if (out_valid)
            begin
                stalled_beats++;
                if (stalled_beats > 2)
                begin
                    $display("more than two beats came out after out_almost_full rose");
                    stop_run();
                end
            end

            if (out_valid)
            begin
                if (expected_q.size() == 0)
                begin
                    $display("an output beat appeared with no write outstanding");
                    stop_run();
                end
                else
                begin
                    exp_beat = expected_q.pop_front();
                    check_value("out_sop", DATA_WIDTH'(out_sop), DATA_WIDTH'(exp_beat.sop));
                    check_value("out_len", DATA_WIDTH'(out_len), DATA_WIDTH'(exp_beat.len));
                    check_value("out_addr", DATA_WIDTH'(out_addr), DATA_WIDTH'(exp_beat.addr));
                    check_value("out_data", out_data, exp_beat.data);
                end
            end
        end
    end

    // ====================
    // Directed tests
    // ====================

    task automatic idle_after_reset();
        repeat (10)
        begin
            @(negedge clk);
            check_value("out_valid", DATA_WIDTH'(out_valid), '0);
            check_value("wr_almost_full", DATA_WIDTH'(wr_almost_full), '0);
        end
    endtask

    task automatic single_beat_stream(input int n_req);
        for (int i = 0; i < n_req; i++)
        begin
            send_request(CL_LEN_1, random_addr());
        end
        end_stream();
        wait_drain();
    endtask

    task automatic mixed_length_stream();
        cl_len_t pattern [8] = '{CL_LEN_2, CL_LEN_1, CL_LEN_4, CL_LEN_1,
                                 CL_LEN_4, CL_LEN_2, CL_LEN_2, CL_LEN_4};
        foreach (pattern[i])
        begin
            send_request(pattern[i], random_addr());
        end
        for (int i = 0; i < 16; i++)
        begin
            send_request(random_len(), random_addr());
        end
        end_stream();
        wait_drain();
    endtask

    task automatic sink_stall_stream(input int n_req);
        stream_active = 1'b1;
        fork
            begin
                for (int i = 0; i < n_req; i++)
                begin
                    send_request(random_len(), random_addr());
                end
                end_stream();
                stream_active = 1'b0;
            end
            throttle_sink();
        join
        wait_drain();
    endtask

    // More beats than heap slots, with the sink blocked at first, so the ring wraps
    task automatic heap_wrap_burst(input int n_req);
        int cycles;
        @(posedge clk);
        out_almost_full <= 1'b1;
        fork
            begin
                for (int i = 0; i < n_req; i++)
                begin
                    send_request(CL_LEN_4, random_addr());
                end
                end_stream();
            end
            begin
                cycles = 0;
                @(negedge clk);
                while (!wr_almost_full)
                begin
                    cycles++;
                    if (cycles > WAIT_TIMEOUT)
                    begin
                        $display("wr_almost_full never rose during the blocked burst");
                        stop_run();
                    end
                    @(negedge clk);
                end
                // The beats held inside must stay below the heap size while blocked
                repeat (50)
                begin
                    @(posedge clk);
                    if (expected_q.size() >= N_HEAP_ENTRIES)
                    begin
                        $display("heap filled up before back-pressure held the sender");
                        stop_run();
                    end
                end
                out_almost_full <= 1'b0;
            end
        join
    endtask

    // Every owed beat has to come out, and no further beat may follow it
    task automatic final_drain();
        wait_drain();
        repeat (20)
        begin
            @(negedge clk);
            check_value("out_valid", DATA_WIDTH'(out_valid), '0);
        end
    endtask

    initial
    begin
        void'($urandom(32'h3756_7dc9));
        clk = 1'b0;
        reset = 1'b1;
        wr_valid = 1'b0;
        wr_sop = 1'b0;
        wr_len = CL_LEN_1;
        wr_addr = '0;
        wr_data = '0;
        out_almost_full = 1'b0;
        stream_active = 1'b0;
        stalled_beats = 0;

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        idle_after_reset();
        single_beat_stream(24);
        mixed_length_stream();
        sink_stall_stream(60);
        heap_wrap_burst(24);
        final_drain();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: verilog/edge_connect.sv
module edge_connect
#(
    parameter int DATA_WIDTH = 512,
    parameter int N_HEAP_ENTRIES = 64,
    parameter int ALMOST_FULL_THRESHOLD = 4
)
(
    input  logic                              clk,
    input  logic                              reset,

    // AFU write requests
    input  logic                              wr_valid,
    input  logic                              wr_sop,
    input  mpf_pkg::cl_len_t                  wr_len,
    input  logic [mpf_pkg::ADDR_WIDTH-1:0]    wr_addr,
    input  logic [DATA_WIDTH-1:0]             wr_data,
    output logic                              wr_almost_full,

    // FIU write beats
    output logic                              out_valid,
    output logic                              out_sop,
    output mpf_pkg::cl_len_t                  out_len,
    output logic [mpf_pkg::ADDR_WIDTH-1:0]    out_addr,
    output logic [DATA_WIDTH-1:0]             out_data,
    input  logic                              out_almost_full,

    // Control-only headers into and out of the shim pipeline
    output logic                              ctl_in_valid,
    output mpf_pkg::cl_len_t                  ctl_in_len,
    output logic [mpf_pkg::ADDR_WIDTH-1:0]    ctl_in_addr,
    output logic [$clog2(N_HEAP_ENTRIES)-1:0] ctl_in_idx,
    input  logic                              ctl_out_valid,
    input  mpf_pkg::cl_len_t                  ctl_out_len,
    input  logic [mpf_pkg::ADDR_WIDTH-1:0]    ctl_out_addr,
    input  logic [$clog2(N_HEAP_ENTRIES)-1:0] ctl_out_idx,
    input  logic                              pipe_almost_full,
    output logic                              fifo_almost_full
);

    import mpf_pkg::*;

    localparam int IDX_WIDTH = $clog2(N_HEAP_ENTRIES);

    logic                  heap_not_full;
    logic [IDX_WIDTH-1:0]  heap_alloc_idx;
    logic [IDX_WIDTH-1:0]  heap_read_idx;
    logic [DATA_WIDTH-1:0] heap_read_data;

    logic                  fifo_not_empty;
    logic                  fifo_deq;
    cl_len_t               fifo_first_len;
    logic [ADDR_WIDTH-1:0] fifo_first_addr;
    logic [IDX_WIDTH-1:0]  fifo_first_idx;

    // FIU side beat generation state
    logic                  beat_go;
    logic                  fiu_sop;
    beat_cnt_t             beats_rem;
    logic [IDX_WIDTH-1:0]  next_idx;

    // Header pipeline that waits out the heap read latency
    logic                  q_valid;
    logic                  q_sop;
    cl_len_t               q_len;
    logic [ADDR_WIDTH-1:0] q_addr;
    logic                  qq_valid;
    logic                  qq_sop;
    cl_len_t               qq_len;
    logic [ADDR_WIDTH-1:0] qq_addr;

    // Every beat's data is parked here until its header comes back out of the pipe
    write_data_heap #(
        .N_ENTRIES(N_HEAP_ENTRIES),
        .DATA_WIDTH(DATA_WIDTH),
        .MIN_FREE_SLOTS(ALMOST_FULL_THRESHOLD + 1)
    ) wr_heap (
        .clk(clk),
        .reset(reset),
        .enq(wr_valid),
        .enq_data(wr_data),
        .not_full(heap_not_full),
        .alloc_idx(heap_alloc_idx),
        .read_idx(heap_read_idx),
        .read_data(heap_read_data),
        .free_en(beat_go),
        .free_idx(heap_read_idx)
    );

    // ====================
    // AFU side
    // ====================

    // Only the first beat travels through the pipe, tagged with its heap slot
    assign ctl_in_valid = wr_valid && wr_sop;
    assign ctl_in_len = wr_len;
    assign ctl_in_addr = wr_addr;
    assign ctl_in_idx = heap_alloc_idx;

    assign wr_almost_full = pipe_almost_full || !heap_not_full;

    // ====================
    // FIU side
    // ====================

    // Headers stack up here since a multi-beat write holds the head for several cycles
    req_fifo #(
        .ALMOST_FULL_THRESHOLD(ALMOST_FULL_THRESHOLD),
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES)
    ) fiu_req_fifo (
        .clk(clk),
        .reset(reset),
        .enq_en(ctl_out_valid),
        .enq_len(ctl_out_len),
        .enq_addr(ctl_out_addr),
        .enq_idx(ctl_out_idx),
        .first_len(fifo_first_len),
        .first_addr(fifo_first_addr),
        .first_idx(fifo_first_idx),
        .not_empty(fifo_not_empty),
        .deq_en(fifo_deq),
        .almost_full(fifo_almost_full)
    );

    always_comb
    begin
        // First beat uses the tagged slot, later beats walk the ring
        heap_read_idx = fiu_sop ? fifo_first_idx : next_idx;

        // A later beat may still be on its way from the AFU, and reaching the
        // allocation pointer means its slot has not been written yet
        beat_go = !out_almost_full && fifo_not_empty && (heap_read_idx != heap_alloc_idx);

        // Release the header with its last beat
        fifo_deq = beat_go &&
                   (fiu_sop ? (fifo_first_len == CL_LEN_1) : (beats_rem == beat_cnt_t'(1)));
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fiu_sop <= 1'b1;
            beats_rem <= '0;
        end
        else
        begin
            if (fifo_deq)
            begin
                fiu_sop <= 1'b1;
            end
            else if (beat_go)
            begin
                fiu_sop <= 1'b0;
            end

            // The length code equals the beats left after the first one
            if (beat_go)
            begin
                beats_rem <= fiu_sop ? beat_cnt_t'(fifo_first_len) : beats_rem - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (beat_go)
        begin
            next_idx <= (heap_read_idx == IDX_WIDTH'(N_HEAP_ENTRIES - 1)) ?
                        '0 : heap_read_idx + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            q_valid <= 1'b0;
            qq_valid <= 1'b0;
        end
        else
        begin
            q_valid <= beat_go;
            qq_valid <= q_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        q_sop <= fiu_sop;
        q_len <= fifo_first_len;
        q_addr <= fifo_first_addr;
        qq_sop <= q_sop;
        qq_len <= q_len;
        qq_addr <= q_addr;
    end

    // Heap data lines up with the second header register
    assign out_valid = qq_valid;
    assign out_sop = qq_sop;
    assign out_len = qq_len;
    assign out_addr = qq_addr;
    assign out_data = heap_read_data;

endmodule

// File: verilog/mpf_pkg.sv
package mpf_pkg;

    // ====================
    // Address
    // ====================

    // Width of a cache-line address
    // All edge, FIFO and pipeline stages carry it unchanged
    localparam int ADDR_WIDTH = 42;

    // ====================
    // Request length
    // ====================

    // Beat-count code of a write request
    // The number of beats is always the code plus one, so a 3-beat code is not legal
    typedef enum logic [1:0]
    {
        CL_LEN_1 = 2'd0,
        CL_LEN_2 = 2'd1,
        CL_LEN_4 = 2'd3
    } cl_len_t;

    // Count of beats that are still to be emitted for the current request
    // Loaded from the cl_len_t code on the first beat and counted down after that
    typedef logic [1:0] beat_cnt_t;

endpackage

// File: verilog/mpf_shim_pipe.sv
module mpf_shim_pipe
#(
    parameter int PIPE_STAGES = 3,
    parameter int N_HEAP_ENTRIES = 64
)
(
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              ctl_in_valid,
    input  mpf_pkg::cl_len_t                  ctl_in_len,
    input  logic [mpf_pkg::ADDR_WIDTH-1:0]    ctl_in_addr,
    input  logic [$clog2(N_HEAP_ENTRIES)-1:0] ctl_in_idx,

    output logic                              ctl_out_valid,
    output mpf_pkg::cl_len_t                  ctl_out_len,
    output logic [mpf_pkg::ADDR_WIDTH-1:0]    ctl_out_addr,
    output logic [$clog2(N_HEAP_ENTRIES)-1:0] ctl_out_idx,

    input  logic                              fifo_almost_full,
    output logic                              pipe_almost_full
);

    import mpf_pkg::*;

    localparam int IDX_WIDTH = $clog2(N_HEAP_ENTRIES);

    logic [PIPE_STAGES-1:0] valid_q;
    cl_len_t                len_q  [PIPE_STAGES];
    logic [ADDR_WIDTH-1:0]  addr_q [PIPE_STAGES];
    logic [IDX_WIDTH-1:0]   idx_q  [PIPE_STAGES];

    // Hold back-pressure while any header is still in flight so the FIFO at
    // the far end never sees more than it can absorb
    assign pipe_almost_full = fifo_almost_full || (|valid_q);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q <= '0;
        end
        else
        begin
            for (int i = PIPE_STAGES - 1; i > 0; i--)
            begin
                valid_q[i] <= valid_q[i-1];
            end
            valid_q[0] <= ctl_in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = PIPE_STAGES - 1; i > 0; i--)
        begin
            len_q[i] <= len_q[i-1];
            addr_q[i] <= addr_q[i-1];
            idx_q[i] <= idx_q[i-1];
        end
        len_q[0] <= ctl_in_len;
        addr_q[0] <= ctl_in_addr;
        idx_q[0] <= ctl_in_idx;
    end

    assign ctl_out_valid = valid_q[PIPE_STAGES-1];
    assign ctl_out_len = len_q[PIPE_STAGES-1];
    assign ctl_out_addr = addr_q[PIPE_STAGES-1];
    assign ctl_out_idx = idx_q[PIPE_STAGES-1];

endmodule

// File: verilog/mpf_top.sv
module mpf_top
#(
    parameter int DATA_WIDTH = 512,
    parameter int N_HEAP_ENTRIES = 64,
    parameter int ALMOST_FULL_THRESHOLD = 4,
    parameter int PIPE_STAGES = 3
)
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           wr_valid,
    input  logic                           wr_sop,
    input  mpf_pkg::cl_len_t               wr_len,
    input  logic [mpf_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0]          wr_data,
    output logic                           wr_almost_full,
    output logic                           out_valid,
    output logic                           out_sop,
    output mpf_pkg::cl_len_t               out_len,
    output logic [mpf_pkg::ADDR_WIDTH-1:0] out_addr,
    output logic [DATA_WIDTH-1:0]          out_data,
    input  logic                           out_almost_full
);

    import mpf_pkg::*;

    localparam int IDX_WIDTH = $clog2(N_HEAP_ENTRIES);

    // Headers between the edge and the shim pipeline
    logic                  ctl_in_valid;
    cl_len_t               ctl_in_len;
    logic [ADDR_WIDTH-1:0] ctl_in_addr;
    logic [IDX_WIDTH-1:0]  ctl_in_idx;
    logic                  ctl_out_valid;
    cl_len_t               ctl_out_len;
    logic [ADDR_WIDTH-1:0] ctl_out_addr;
    logic [IDX_WIDTH-1:0]  ctl_out_idx;
    logic                  pipe_almost_full;
    logic                  fifo_almost_full;

    edge_connect #(
        .DATA_WIDTH(DATA_WIDTH),
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES),
        .ALMOST_FULL_THRESHOLD(ALMOST_FULL_THRESHOLD)
    ) edge_i (
        .clk(clk), .reset(reset),
        .wr_valid(wr_valid), .wr_sop(wr_sop), .wr_len(wr_len), .wr_addr(wr_addr),
        .wr_data(wr_data), .wr_almost_full(wr_almost_full),
        .out_valid(out_valid), .out_sop(out_sop), .out_len(out_len), .out_addr(out_addr),
        .out_data(out_data), .out_almost_full(out_almost_full),
        .ctl_in_valid(ctl_in_valid), .ctl_in_len(ctl_in_len),
        .ctl_in_addr(ctl_in_addr), .ctl_in_idx(ctl_in_idx),
        .ctl_out_valid(ctl_out_valid), .ctl_out_len(ctl_out_len),
        .ctl_out_addr(ctl_out_addr), .ctl_out_idx(ctl_out_idx),
        .pipe_almost_full(pipe_almost_full), .fifo_almost_full(fifo_almost_full)
    );

    // Stand-in for the request-processing shims
    mpf_shim_pipe #(
        .PIPE_STAGES(PIPE_STAGES),
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES)
    ) shim_pipe (
        .clk(clk), .reset(reset),
        .ctl_in_valid(ctl_in_valid), .ctl_in_len(ctl_in_len),
        .ctl_in_addr(ctl_in_addr), .ctl_in_idx(ctl_in_idx),
        .ctl_out_valid(ctl_out_valid), .ctl_out_len(ctl_out_len),
        .ctl_out_addr(ctl_out_addr), .ctl_out_idx(ctl_out_idx),
        .fifo_almost_full(fifo_almost_full), .pipe_almost_full(pipe_almost_full)
    );

endmodule

// File: verilog/req_fifo.sv
module req_fifo
#(
    parameter int ALMOST_FULL_THRESHOLD = 4,
    parameter int N_HEAP_ENTRIES = 64
)
(
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              enq_en,
    input  mpf_pkg::cl_len_t                  enq_len,
    input  logic [mpf_pkg::ADDR_WIDTH-1:0]    enq_addr,
    input  logic [$clog2(N_HEAP_ENTRIES)-1:0] enq_idx,

    output mpf_pkg::cl_len_t                  first_len,
    output logic [mpf_pkg::ADDR_WIDTH-1:0]    first_addr,
    output logic [$clog2(N_HEAP_ENTRIES)-1:0] first_idx,
    output logic                              not_empty,
    input  logic                              deq_en,
    output logic                              almost_full
);

    import mpf_pkg::*;

    // Two spare entries beyond the threshold cover the header already in
    // the pipe when almost-full rises
    localparam int N_ENTRIES = ALMOST_FULL_THRESHOLD + 2;
    localparam int PTR_WIDTH = $clog2(N_ENTRIES);
    localparam int CNT_WIDTH = $clog2(N_ENTRIES + 1);
    localparam int IDX_WIDTH = $clog2(N_HEAP_ENTRIES);

    cl_len_t              len_mem  [N_ENTRIES];
    logic [ADDR_WIDTH-1:0] addr_mem [N_ENTRIES];
    logic [IDX_WIDTH-1:0]  idx_mem  [N_ENTRIES];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;

    // Head comes straight out of the register array
    assign first_len = len_mem[rd_ptr];
    assign first_addr = addr_mem[rd_ptr];
    assign first_idx = idx_mem[rd_ptr];
    assign not_empty = (count != '0);
    assign almost_full = ((CNT_WIDTH'(N_ENTRIES) - count) <= CNT_WIDTH'(ALMOST_FULL_THRESHOLD));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(N_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (deq_en)
            begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(N_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_WIDTH'(enq_en) - CNT_WIDTH'(deq_en);
        end
    end

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            len_mem[wr_ptr] <= enq_len;
            addr_mem[wr_ptr] <= enq_addr;
            idx_mem[wr_ptr] <= enq_idx;
        end
    end

endmodule

// File: verilog/write_data_heap.sv
module write_data_heap
#(
    parameter int N_ENTRIES = 64,
    parameter int DATA_WIDTH = 512,
    parameter int MIN_FREE_SLOTS = 5
)
(
    input  logic                         clk,
    input  logic                         reset,

    // Allocation side, one slot per incoming beat
    input  logic                         enq,
    input  logic [DATA_WIDTH-1:0]        enq_data,
    output logic                         not_full,
    output logic [$clog2(N_ENTRIES)-1:0] alloc_idx,

    // Read and release side
    input  logic [$clog2(N_ENTRIES)-1:0] read_idx,
    output logic [DATA_WIDTH-1:0]        read_data,
    input  logic                         free_en,
    input  logic [$clog2(N_ENTRIES)-1:0] free_idx
);

    localparam int IDX_WIDTH = $clog2(N_ENTRIES);
    localparam int CNT_WIDTH = $clog2(N_ENTRIES + 1);

    logic [DATA_WIDTH-1:0] mem [N_ENTRIES];
    logic [DATA_WIDTH-1:0] mem_rd;

    // Ring pointers and the number of slots not in use
    logic [IDX_WIDTH-1:0] wr_ptr;
    logic [IDX_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] free_cnt;

    // Slots are handed out in ring order so the beats of one request land
    // on consecutive indices
    assign alloc_idx = wr_ptr;

    // Keep a reserve of slots for beats that are already on their way
    assign not_full = (free_cnt > CNT_WIDTH'(MIN_FREE_SLOTS));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            free_cnt <= CNT_WIDTH'(N_ENTRIES);
        end
        else
        begin
            if (enq)
            begin
                wr_ptr <= (wr_ptr == IDX_WIDTH'(N_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            end

            // Release is strictly in allocation order, so the ring read pointer
            // always names the slot being freed
            if (free_en)
            begin
                rd_ptr <= (rd_ptr == IDX_WIDTH'(N_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
            end

            case ({enq, free_en})
                2'b10: free_cnt <= free_cnt - 1'b1;
                2'b01: free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt;
            endcase
        end
    end

    // Data store with a two-cycle read: one memory cycle, then the output register
    // A slot freed this cycle is read before it can be allocated again
    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            mem[wr_ptr] <= enq_data;
        end

        mem_rd <= mem[read_idx];
        read_data <= mem_rd;
    end

endmodule
